// File: logic/fdc_consts.svh
`ifndef FDC_CONSTS_SVH
`define FDC_CONSTS_SVH

// ---------------------------------------------------------------------------
// host register addresses
// ---------------------------------------------------------------------------
`define FDC_A_CMD     2'd0  // command on write, status on read
`define FDC_A_TRACK   2'd1
`define FDC_A_SECTOR  2'd2
`define FDC_A_DATA    2'd3

// ---------------------------------------------------------------------------
// command timing in ce cycles
// ---------------------------------------------------------------------------
`define FDC_WAIT_CYCLES  4000  // type I busy period
`define FDC_SEEK_CYCLES  1023  // before the first byte of a sector
`define FDC_DRQ_DELAY    15    // before each read DRQ

// timer reloads
`define FDC_WATCHDOG_CYCLES  4096
`define FDC_INDEX_PERIOD     35000
`define FDC_INDEX_WIDTH      100

// smallest sector, size code 0
`define FDC_SECTOR_BASE  128

`endif

// File: logic/fdc_pkg.sv
package fdc_pkg;

	// controller states
	typedef enum logic [4:0] {
		idle,
		wait_read,
		read_prep,
		read_delay,
		read_wait_host,
		read_next,
		write_wait_host,
		write_next,
		write_done,
		delay_load,
		delay_run,
		abort,
		end_cmd
	} fdc_state_e;

	// top nibble of the command byte
	typedef enum logic [3:0] {
		restore, seek, step, step_upd,
		step_in, step_in_upd, step_out, step_out_upd,
		read_sec, read_sec_m, write_sec, write_sec_m,
		read_addr, force_int, read_trk, write_trk
	} fdc_cmd_e;

	typedef struct packed {
		logic       io_en;
		logic       rd;
		logic       wr;
		logic [1:0] addr;
		logic [7:0] din;
	} host_bus_t;

	// single ce cycle pulses from the register block
	typedef struct packed {
		logic       cmd_load;
		logic       force_int;
		logic       track_wr;
		logic       sector_wr;
		logic       data_rd_done;
		logic       data_wr_done;
		logic       status_rd_done;
		logic [7:0] value;       // byte written by the host
	} reg_event_t;

	typedef struct packed {
		logic [7:0] track;
		logic [7:0] sector;
		logic [7:0] disk_track;
		logic [7:0] ra_byte;     // current READ ADDRESS byte
		logic [1:0] rd_src;      // 0 data reg, 1 buffer, 2 id bytes
		logic       headloaded;
		logic       seekerr;
		logic       crcerr;
		logic       lostdata;
		logic       wrfault;
		logic       cmd_mode;
		logic       drq;
		logic       busy;
	} fdc_status_t;

	typedef struct packed {
		logic [7:0]  spt;        // sectors per track
		logic [1:0]  size_code;  // as reported in the id field
		logic [10:0] sec_len;
	} geom_t;

	typedef struct packed {
		logic [19:0] addr;
		logic        read;
		logic        write;
		logic [7:0]  dout;
	} buff_bus_t;

endpackage

// File: logic/fdc_regs.sv
`timescale 1ns/1ps
`include "fdc_consts.svh"

module fdc_regs (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               ce,
	input  fdc_pkg::host_bus_t host,
	input  fdc_pkg::fdc_status_t stat,
	input  logic               ready,
	input  logic               index,
	input  logic [7:0]         buff_din,
	input  logic               cmd_taken,   // controller accepted the command
	output fdc_pkg::reg_event_t evt,
	output fdc_pkg::fdc_cmd_e  cmd,
	output logic [7:0]         cmd_byte,
	output logic               pending,
	output logic [7:0]         data_reg,
	output logic [7:0]         dout
);
	import fdc_pkg::*;

	logic       old_rd, old_wr;
	logic [1:0] cur_addr;     // address seen at the start of the access
	logic       rde, wre;
	logic       rd_fall, wr_rise, wr_fall, rd_rise;
	logic       is_force;
	logic [7:0] status;

	assign rde = host.rd & host.io_en;
	assign wre = host.wr & host.io_en;
	assign rd_rise = rde & ~old_rd;
	assign rd_fall = old_rd & ~rde;
	assign wr_rise = wre & ~old_wr;
	assign wr_fall = old_wr & ~wre;
	assign is_force = (fdc_cmd_e'(host.din[7:4]) == force_int);

	assign cmd = fdc_cmd_e'(cmd_byte[7:4]);

	// ---------------------------------------------------------------------------
	// strobe edges and event pulses
	// ---------------------------------------------------------------------------
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_rd <= 1'b0;
			old_wr <= 1'b0;
			cur_addr <= `FDC_A_CMD;
			evt <= '0;
			pending <= 1'b0;
		end else if (ce) begin
			old_rd <= rde;
			old_wr <= wre;
			if (rd_rise || wr_rise)
				cur_addr <= host.addr;

			evt.value <= host.din;
			evt.cmd_load <= wr_rise && (host.addr == `FDC_A_CMD) && !is_force;
			evt.force_int <= wr_rise && (host.addr == `FDC_A_CMD) && is_force;
			evt.track_wr <= wr_rise && (host.addr == `FDC_A_TRACK);
			evt.sector_wr <= wr_rise && (host.addr == `FDC_A_SECTOR);
			evt.data_rd_done <= rd_fall && (cur_addr == `FDC_A_DATA);
			evt.data_wr_done <= wr_fall && (cur_addr == `FDC_A_DATA);
			evt.status_rd_done <= rd_fall && (cur_addr == `FDC_A_CMD);

			if (cmd_taken)
				pending <= 1'b0;
			else if (wr_rise && (host.addr == `FDC_A_CMD) && !is_force)
				pending <= 1'b1;
		end
	end

	// command and data bytes
	always_ff @(posedge clk_sys) begin
		if (ce && wr_rise) begin
			if ((host.addr == `FDC_A_CMD) && !is_force && !pending)
				cmd_byte <= host.din;   // ignored while one is waiting
			if (host.addr == `FDC_A_DATA)
				data_reg <= host.din;
		end
	end

	// status in type I or type II/III layout
	assign status = stat.cmd_mode ?
		{~ready, 1'b0, stat.wrfault, stat.seekerr, stat.crcerr, stat.lostdata, stat.drq,
			stat.busy | pending} :
		{~ready, 1'b0, stat.headloaded, stat.seekerr, stat.crcerr, stat.disk_track == 8'd0,
			index, stat.busy | pending};

	always_comb begin
		case (host.addr)
			`FDC_A_TRACK:  dout = stat.track;
			`FDC_A_SECTOR: dout = stat.sector;
			`FDC_A_DATA: begin
				case (stat.rd_src)
					2'd0:    dout = data_reg;
					2'd1:    dout = buff_din;   // sector data straight from RAM
					default: dout = stat.ra_byte;
				endcase
			end
			default:       dout = status;
		endcase
	end

endmodule

// File: logic/fdc_ctrl.sv
`timescale 1ns/1ps
`include "fdc_consts.svh"

module fdc_ctrl (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 ce,
	input  fdc_pkg::reg_event_t  evt,
	input  fdc_pkg::fdc_cmd_e    cmd,
	input  logic [7:0]           cmd_byte,
	input  logic                 pending,
	input  logic [7:0]           data_reg,
	input  fdc_pkg::geom_t       geom,
	input  logic                 side,
	input  logic                 ready,
	input  logic                 bark,
	output logic                 cmd_taken,
	output fdc_pkg::fdc_status_t stat,
	output logic [7:0]           disk_track,   // real head position
	output logic [7:0]           sector,
	output logic [9:0]           byte_addr,
	output logic                 buff_rd,
	output logic                 buff_wr,
	output logic                 intrq,
	output logic                 arm
);
	import fdc_pkg::*;

	fdc_state_e  state;
	logic [7:0]  track;
	logic [10:0] rdlen;          // bytes left in this transfer
	logic        step_dir;       // 1 steps out
	logic        multi;
	logic        read_type;      // 0 for READ ADDRESS
	logic        headloaded, seekerr, crcerr, lostdata, wrfault;
	logic        cmd_mode, drq, busy;
	logic [11:0] wait_cnt;
	logic [9:0]  seek_cnt;
	logic [3:0]  drq_cnt;
	logic        dir;
	logic [7:0]  next_track;
	logic [10:0] rdlen_m1;
	logic [7:0]  ra_byte;

	assign dir = cmd_byte[6] ? cmd_byte[5] : step_dir;
	assign next_track = dir ? disk_track - 8'd1 : disk_track + 8'd1;
	assign rdlen_m1 = rdlen - 11'd1;

	assign cmd_taken = ((state == idle) && pending) || (state == abort);

	// id field bytes
	always_comb begin
		case (byte_addr[2:0])
			3'd0:    ra_byte = disk_track;
			3'd1:    ra_byte = {7'd0, side};
			3'd2:    ra_byte = sector;
			3'd3:    ra_byte = {6'd0, geom.size_code};
			default: ra_byte = 8'd0;   // crc bytes
		endcase
	end

	always_comb begin
		stat.track = track;
		stat.sector = sector;
		stat.disk_track = disk_track;
		stat.ra_byte = ra_byte;
		stat.rd_src = (state == idle) ? 2'd0 : (buff_rd ? 2'd1 : 2'd2);
		stat.headloaded = headloaded;
		stat.seekerr = seekerr;
		stat.crcerr = crcerr;
		stat.lostdata = lostdata;
		stat.wrfault = wrfault;
		stat.cmd_mode = cmd_mode;
		stat.drq = drq;
		stat.busy = busy;
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			state <= idle;
			track <= 8'd0;
			sector <= 8'd0;
			disk_track <= 8'd0;
			byte_addr <= 10'd0;
			rdlen <= 11'd0;
			step_dir <= 1'b0;
			multi <= 1'b0;
			read_type <= 1'b0;
			{headloaded, seekerr, crcerr, lostdata, wrfault} <= '0;
			{cmd_mode, drq, busy, intrq} <= '0;
			{buff_rd, buff_wr, arm} <= '0;
			wait_cnt <= 12'd0;
			seek_cnt <= 10'(`FDC_SEEK_CYCLES);
			drq_cnt <= 4'd0;
		end else if (ce) begin
			if (evt.cmd_load || evt.status_rd_done)
				intrq <= 1'b0;
			if (evt.track_wr && !busy)
				track <= evt.value;
			if (evt.sector_wr && !busy)
				sector <= evt.value;

			case (state)
				idle: if (pending) begin
					cmd_mode <= cmd_byte[7];
					case (cmd)
						restore, seek, step, step_upd, step_in, step_in_upd,
						step_out, step_out_upd: begin
							busy <= 1'b1;
							headloaded <= cmd_byte[3];
							state <= delay_load;
							if (cmd == restore) begin
								track <= 8'd0;
								disk_track <= 8'd0;
							end else if (cmd == seek) begin
								track <= data_reg;
								disk_track <= data_reg;
							end else begin
								if (cmd_byte[6])
									step_dir <= cmd_byte[5];   // remembered for plain STEP
								disk_track <= next_track;
								if (cmd_byte[4])
									track <= next_track;
							end
						end
						read_sec, read_sec_m, read_addr: begin
							busy <= 1'b1;
							{wrfault, seekerr, crcerr, lostdata} <= '0;
							state <= wait_read;
							if (cmd == read_addr) begin
								multi <= 1'b0;
								rdlen <= 11'd6;
								read_type <= 1'b0;
							end else begin
								multi <= cmd_byte[4];
								rdlen <= geom.sec_len;
								read_type <= 1'b1;
							end
						end
						write_sec, write_sec_m: begin
							{busy, drq} <= 2'b11;
							{wrfault, seekerr, crcerr, lostdata} <= '0;
							multi <= cmd_byte[4];
							rdlen <= geom.sec_len;
							byte_addr <= 10'd0;
							buff_wr <= 1'b1;
							state <= write_wait_host;
						end
						read_trk, write_trk: begin
							busy <= 1'b1;
							{seekerr, crcerr, lostdata} <= '0;
							wrfault <= cmd_byte[4];   // disk treated as read only
							state <= delay_load;
						end
						default: {busy, drq} <= 2'b00;
					endcase
				end

				// -------------------------------------------------------------------
				// buffer to host
				// -------------------------------------------------------------------
				wait_read: begin
					if (!ready) begin
						seekerr <= 1'b1;
						crcerr <= 1'b1;
						state <= end_cmd;
					end else if (seek_cnt != 10'd0) begin
						seek_cnt <= seek_cnt - 10'd1;
					end else begin
						seek_cnt <= 10'(`FDC_SEEK_CYCLES);
						if (multi && (sector > geom.spt)) begin
							seekerr <= 1'b1;   // ran off the end of the track
							multi <= 1'b0;
							state <= end_cmd;
						end else begin
							buff_rd <= read_type;
							byte_addr <= 10'd0;
							state <= read_prep;
						end
					end
				end
				read_prep: begin
					arm <= 1'b1;
					drq_cnt <= 4'(`FDC_DRQ_DELAY);
					drq <= 1'b0;
					state <= read_delay;
				end
				read_delay: begin
					if (drq_cnt != 4'd0) begin
						drq_cnt <= drq_cnt - 4'd1;
					end else begin
						arm <= 1'b0;         // watchdog starts here
						drq <= 1'b1;
						state <= read_wait_host;
					end
				end
				read_wait_host: if (bark || evt.data_rd_done) begin
					drq <= 1'b0;
					if (bark)
						lostdata <= 1'b1;
					if (rdlen_m1 == 11'd0) begin
						if (multi) begin
							sector <= sector + 8'd1;
							rdlen <= geom.sec_len;
							state <= wait_read;
						end else begin
							state <= end_cmd;
						end
					end else begin
						state <= read_next;
					end
				end
				read_next: begin
					byte_addr <= byte_addr + 10'd1;
					rdlen <= rdlen_m1;
					state <= read_prep;
				end

				// -------------------------------------------------------------------
				// host to buffer
				// -------------------------------------------------------------------
				write_wait_host: if (evt.data_wr_done) begin
					drq <= 1'b0;
					state <= write_next;
				end
				write_next: begin
					byte_addr <= byte_addr + 10'd1;
					rdlen <= rdlen_m1;
					if (rdlen_m1 == 11'd0) begin
						state <= write_done;
					end else begin
						drq <= 1'b1;
						state <= write_wait_host;
					end
				end
				write_done: begin
					if (!ready) begin
						wrfault <= 1'b1;
						state <= end_cmd;
					end else if (multi && (sector < geom.spt)) begin
						sector <= sector + 8'd1;
						drq <= 1'b1;
						rdlen <= geom.sec_len;
						byte_addr <= 10'd0;
						state <= write_wait_host;
					end else begin
						multi <= 1'b0;
						state <= end_cmd;
					end
				end

				delay_load: begin
					wait_cnt <= 12'(`FDC_WAIT_CYCLES);
					state <= delay_run;
				end
				delay_run: begin
					if (wait_cnt != 12'd0)
						wait_cnt <= wait_cnt - 12'd1;
					else
						state <= end_cmd;
				end
				abort: begin
					rdlen <= 11'd0;
					state <= end_cmd;
				end
				default: begin   // end_cmd
					{buff_rd, buff_wr, arm} <= '0;
					{busy, drq} <= 2'b00;
					intrq <= 1'b1;
					seek_cnt <= 10'(`FDC_SEEK_CYCLES);
					state <= idle;
				end
			endcase

			// FORCE INTERRUPT overrides whatever the FSM chose
			if (evt.force_int) begin
				intrq <= 1'b0;
				cmd_mode <= 1'b0;
				if (state != idle)
					state <= abort;
				else
					{wrfault, seekerr, crcerr, lostdata} <= '0;
			end
		end
	end

endmodule

// File: logic/fdc_geometry.sv
`timescale 1ns/1ps
`include "fdc_consts.svh"

module fdc_geometry (
	input  logic [2:0]     size_code,
	input  logic [7:0]     disk_track,
	input  logic           side,
	input  logic [7:0]     sector,      // numbered from 1
	input  logic [9:0]     byte_addr,
	output fdc_pkg::geom_t geom,
	output logic [19:0]    buff_addr
);
	import fdc_pkg::*;

	logic [8:0]  trk_side;   // physical track index of the image
	logic [19:0] lin_sec;

	// ---------------------------------------------------------------------------
	// track layouts
	// ---------------------------------------------------------------------------
	always_comb begin
		case (size_code)
			3'd1: begin
				geom.spt = 8'd16;
				geom.size_code = 2'd1;
			end
			3'd2: begin
				geom.spt = 8'd9;
				geom.size_code = 2'd2;
			end
			3'd3: begin
				geom.spt = 8'd5;
				geom.size_code = 2'd3;
			end
			3'd4: begin
				geom.spt = 8'd10;   // 512 byte sectors again
				geom.size_code = 2'd2;
			end
			default: begin
				geom.spt = 8'd26;
				geom.size_code = 2'd0;
			end
		endcase
		geom.sec_len = 11'(`FDC_SECTOR_BASE) << geom.size_code;
	end

	assign trk_side = {disk_track, 1'b0} + 9'(side);
	assign lin_sec = 20'(trk_side) * 20'(geom.spt) + 20'(sector) - 20'd1;
	assign buff_addr = lin_sec * 20'(geom.sec_len) + 20'(byte_addr);

endmodule

// File: logic/fdc_timers.sv
`timescale 1ns/1ps
`include "fdc_consts.svh"

module fdc_timers (
	input  logic clk_sys,
	input  logic reset,
	input  logic ce,
	input  logic arm,     // holds the watchdog in reload
	output logic index,
	output logic bark
);

	logic [15:0] idx_cnt;
	logic [12:0] wd_cnt;

	// ---------------------------------------------------------------------------
	// index pulse, one per revolution
	// ---------------------------------------------------------------------------
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			idx_cnt <= 16'd0;
		end else if (ce) begin
			if (idx_cnt == 16'(`FDC_INDEX_PERIOD - 1))
				idx_cnt <= 16'd0;
			else
				idx_cnt <= idx_cnt + 16'd1;
		end
	end

	assign index = (idx_cnt < 16'(`FDC_INDEX_WIDTH));

	// lost data watchdog
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			wd_cnt <= 13'(`FDC_WATCHDOG_CYCLES);
		end else if (ce) begin
			if (arm)
				wd_cnt <= 13'(`FDC_WATCHDOG_CYCLES);
			else if (wd_cnt != 13'd0)
				wd_cnt <= wd_cnt - 13'd1;
		end
	end

	assign bark = (wd_cnt == 13'd0);

endmodule

// File: logic/fdc_top.sv
`timescale 1ns/1ps
`include "fdc_consts.svh"

module fdc_top (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                ce,        // cpu clock rate enable
	input  fdc_pkg::host_bus_t  host,
	input  logic [7:0]          buff_din,
	input  logic [2:0]          size_code,
	input  logic                side,
	input  logic                ready,     // disk present
	output logic [7:0]          dout,
	output logic                drq,
	output logic                intrq,
	output logic                busy,
	output fdc_pkg::buff_bus_t  buff
);
	import fdc_pkg::*;

	reg_event_t  evt;
	fdc_cmd_e    cmd;
	fdc_status_t stat;
	geom_t       geom;
	logic [7:0]  cmd_byte, data_reg;
	logic        pending, cmd_taken;
	logic [7:0]  disk_track, sector;
	logic [9:0]  byte_addr;
	logic        buff_rd, buff_wr;
	logic        index, bark, arm;
	logic [19:0] buff_addr;

	fdc_regs i_fdc_regs (
		.clk_sys, .reset, .ce, .host, .stat, .ready, .index, .buff_din, .cmd_taken,
		.evt, .cmd, .cmd_byte, .pending, .data_reg, .dout
	);

	fdc_ctrl i_fdc_ctrl (
		.clk_sys, .reset, .ce, .evt, .cmd, .cmd_byte, .pending, .data_reg, .geom,
		.side, .ready, .bark, .cmd_taken, .stat, .disk_track, .sector, .byte_addr,
		.buff_rd, .buff_wr, .intrq, .arm
	);

	fdc_geometry i_fdc_geometry (
		.size_code, .disk_track, .side, .sector, .byte_addr, .geom, .buff_addr
	);

	fdc_timers i_fdc_timers (.clk_sys, .reset, .ce, .arm, .index, .bark);

	assign drq = stat.drq;
	assign busy = stat.busy;

	// buffer strobes only while the data port is addressed
	assign buff.addr = buff_addr;
	assign buff.read = (host.addr == `FDC_A_DATA) && buff_rd;
	assign buff.write = (host.addr == `FDC_A_DATA) && buff_wr;
	assign buff.dout = host.din;

endmodule

// File: tb/fdc_assertions.sv
`timescale 1ns/1ps

module fdc_assertions (
	input logic                clk_sys,
	input logic                reset,
	input logic                drq,
	input logic                busy,
	input fdc_pkg::buff_bus_t  buff
);
	import fdc_pkg::*;

	int fails = 0;   // failed assertions so far

	// data requests only inside a command
	drq_needs_busy: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(drq) |-> busy)
		else begin
			$error("drq rose while busy was low");
			fails++;
		end

	// quiet right after reset
	idle_after_reset: assert property (@(posedge clk_sys)
		$fell(reset) |-> (!busy && !drq))
		else begin
			$error("busy or drq high after reset release");
			fails++;
		end

	no_read_and_write: assert property (@(posedge clk_sys) disable iff (reset)
		!(buff.read && buff.write))
		else begin
			$error("buffer read and write strobes high together");
			fails++;
		end

endmodule

bind fdc_top fdc_assertions i_fdc_assertions (
	.clk_sys(clk_sys), .reset(reset), .drq(drq), .busy(busy), .buff(buff)
);

// File: tb/tb_fdc.sv
`timescale 1ns/1ps
`include "fdc_consts.svh"

module tb_fdc;
	import fdc_pkg::*;

	logic clk_sys, reset, ce, side, ready;
	logic [2:0] size_code;
	host_bus_t host;
	buff_bus_t buff;
	logic [7:0] dout, buff_din;
	logic drq, intrq, busy;
	logic [7:0] ram [0:1048575];   // 1 MB disk image
	int errors, checks, wr_seen;
	bit sec_check;
	int exp_code, exp_trk, exp_side, exp_sec, exp_byte;
	logic [7:0] exp_wdata;

	fdc_top i_fdc_top (.clk_sys, .reset, .ce, .host, .buff_din, .size_code, .side, .ready,
		.dout, .drq, .intrq, .busy, .buff);

	assign buff_din = ram[buff.addr];
	always #2 clk_sys = ~clk_sys;

	// ---------------------------------------------------------------------------
	// reference model of the track layouts
	// ---------------------------------------------------------------------------
	function automatic int sectors_per_track(input int code);
		case (code)
			1: return 16;
			2: return 9;
			3: return 5;
			4: return 10;
			default: return 26;
		endcase
	endfunction

	function automatic int id_size(input int code);
		if (code == 4)
			return 2;   // 512 byte sectors, ten per track
		return (code > 4) ? 0 : code;
	endfunction

	function automatic int sector_length(input int code);
		return `FDC_SECTOR_BASE << id_size(code);
	endfunction

	function automatic logic [19:0] buff_address(input int code, trk, sd, sec, off);
		return ((2 * trk + sd) * sectors_per_track(code) + sec - 1) * sector_length(code) + off;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	// ---------------------------------------------------------------------------
	// host tasks
	// ---------------------------------------------------------------------------
	task automatic reg_write(input logic [1:0] a, input logic [7:0] v);
		@(posedge clk_sys);
		host.io_en <= 1'b1;
		host.addr <= a;
		host.din <= v;
		host.wr <= 1'b1;
		@(posedge clk_sys);
		host.wr <= 1'b0;
		host.io_en <= 1'b0;
		repeat (3) @(posedge clk_sys);   // event reaches the FSM
	endtask

	task automatic reg_read(input logic [1:0] a, output logic [7:0] v);
		@(posedge clk_sys);
		host.io_en <= 1'b1;
		host.addr <= a;
		host.rd <= 1'b1;
		@(negedge clk_sys);
		v = dout;
		@(posedge clk_sys);
		host.rd <= 1'b0;
		host.io_en <= 1'b0;
		repeat (3) @(posedge clk_sys);
	endtask

	task automatic wait_high(input string name, input int limit);
		int n;
		bit seen;
		n = 0;
		seen = 0;
		while (!seen && n < limit) begin
			@(negedge clk_sys);
			case (name)
				"drq":   seen = drq;
				"intrq": seen = intrq;
				default: seen = busy;
			endcase
			n++;
		end
		if (!seen) begin
			errors++;
			$display("timeout at %0t: %s did not rise within %0d cycles", $time, name, limit);
		end
	endtask

	// wait for the end of a command, then read status to clear intrq
	task automatic finish_cmd(input int limit, output logic [7:0] st);
		wait_high("intrq", limit);
		check("busy", busy, 0);
		reg_read(`FDC_A_CMD, st);
	endtask

	task automatic seek_to(input int t);
		logic [7:0] st;
		reg_write(`FDC_A_DATA, t[7:0]);
		reg_write(`FDC_A_CMD, 8'h10);
		wait_high("busy", 10);
		finish_cmd(`FDC_WAIT_CYCLES + 500, st);
	endtask

	task automatic read_sectors(input int code, trk, sd, sec, input logic [7:0] cmd_v,
		input int nsec);
		logic [7:0] v;
		@(posedge clk_sys);
		size_code <= 3'(code);
		side <= sd[0];
		exp_code = code;
		exp_trk = trk;
		exp_side = sd;
		reg_write(`FDC_A_SECTOR, sec[7:0]);
		sec_check = 1;
		reg_write(`FDC_A_CMD, cmd_v);
		for (int s = 0; s < nsec; s++) begin
			for (int b = 0; b < sector_length(code); b++) begin
				exp_sec = sec + s;
				exp_byte = b;
				wait_high("drq", `FDC_SEEK_CYCLES + 200);
				reg_read(`FDC_A_DATA, v);
			end
		end
		sec_check = 0;
	endtask

	// checks every data byte and every buffer write
	always @(negedge clk_sys) begin
		if (sec_check && host.io_en && host.rd && host.addr == `FDC_A_DATA) begin
			check("buff.read", buff.read, 1);
			check("dout", dout, ram[buff_address(exp_code, exp_trk, exp_side, exp_sec, exp_byte)]);
		end
		if (buff.write && host.io_en && host.wr) begin
			check("buff.addr", buff.addr,
				buff_address(exp_code, exp_trk, exp_side, exp_sec, exp_byte));
			check("buff.dout", buff.dout, exp_wdata);
			ram[buff.addr] = buff.dout;
			wr_seen++;
		end
	end

	initial begin
		logic [7:0] v, st;
		int t, sd, sec, len;
		clk_sys = 0;
		reset = 1;
		ce = 1;
		ready = 1;
		side = 0;
		size_code = 3'd0;
		host = '0;
		v = $urandom(32'h4d2c);
		for (int i = 0; i < 1048576; i++)
			ram[i] = $urandom;
		repeat (5) @(posedge clk_sys);
		reset <= 1'b0;
		repeat (2) @(posedge clk_sys);

		check("drq", drq, 0);
		check("intrq", intrq, 0);
		check("busy", busy, 0);
		reg_read(`FDC_A_TRACK, v);
		check("track", v, 0);
		reg_read(`FDC_A_SECTOR, v);
		check("sector", v, 0);

		// ---------------------------------------------------------------------------
		// type I commands and READ ADDRESS
		// ---------------------------------------------------------------------------
		t = 1 + $urandom % 79;
		seek_to(t);
		reg_read(`FDC_A_TRACK, v);
		check("track", v, t);
		reg_write(`FDC_A_CMD, 8'h00);   // restore
		wait_high("busy", 10);
		finish_cmd(`FDC_WAIT_CYCLES + 500, st);
		reg_read(`FDC_A_TRACK, v);
		check("track", v, 0);
		repeat (2) begin
			reg_write(`FDC_A_CMD, 8'h50);   // step in, update track
			wait_high("busy", 10);
			finish_cmd(`FDC_WAIT_CYCLES + 500, st);
		end
		reg_read(`FDC_A_TRACK, v);
		check("track", v, 2);
		sd = $urandom % 2;
		sec = 1 + $urandom % 5;
		@(posedge clk_sys);
		size_code <= 3'd3;
		side <= sd[0];
		reg_write(`FDC_A_SECTOR, sec[7:0]);
		reg_write(`FDC_A_CMD, 8'hc0);
		for (int b = 0; b < 6; b++) begin
			wait_high("drq", `FDC_SEEK_CYCLES + 200);
			reg_read(`FDC_A_DATA, v);
			case (b)
				0: check("id track", v, 2);
				1: check("id side", v, sd);
				2: check("id sector", v, sec);
				3: check("id size", v, id_size(3));
				default: check("id crc", v, 0);
			endcase
		end
		finish_cmd(`FDC_SEEK_CYCLES + 200, st);

		// single sector reads on every layout
		for (int code = 0; code < 5; code++) begin
			t = $urandom % 80;
			seek_to(t);
			read_sectors(code, t, $urandom % 2, 1 + $urandom % sectors_per_track(code),
				8'h80, 1);
			finish_cmd(100, st);
		end

		// multi sector read runs off the end of the track
		t = $urandom % 80;
		seek_to(t);
		read_sectors(1, t, 0, sectors_per_track(1) - 1, 8'h90, 2);
		finish_cmd(`FDC_SEEK_CYCLES + 200, st);
		check("status.seekerr", st[4], 1);

		// ---------------------------------------------------------------------------
		// sector write
		// ---------------------------------------------------------------------------
		t = $urandom % 80;
		seek_to(t);
		sec = 1 + $urandom % 9;
		len = sector_length(2);
		@(posedge clk_sys);
		size_code <= 3'd2;
		side <= 1'b1;
		exp_code = 2;
		exp_trk = t;
		exp_side = 1;
		exp_sec = sec;
		wr_seen = 0;
		reg_write(`FDC_A_SECTOR, sec[7:0]);
		reg_write(`FDC_A_CMD, 8'ha0);
		for (int b = 0; b < len; b++) begin
			exp_byte = b;
			exp_wdata = $urandom;
			wait_high("drq", 200);
			reg_write(`FDC_A_DATA, exp_wdata);
		end
		finish_cmd(100, st);
		check("buffer writes", wr_seen, len);

		// lost data, then FORCE INTERRUPT
		@(posedge clk_sys);
		size_code <= 3'd0;
		reg_write(`FDC_A_SECTOR, 8'd1);
		reg_write(`FDC_A_CMD, 8'h80);
		wait_high("drq", `FDC_SEEK_CYCLES + 200);
		repeat (`FDC_WATCHDOG_CYCLES + 50) @(posedge clk_sys);
		reg_read(`FDC_A_CMD, st);
		check("status.lostdata", st[2], 1);
		reg_write(`FDC_A_CMD, 8'hd0);
		finish_cmd(20, st);

		errors += i_fdc_top.i_fdc_assertions.fails;
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: project.f
+incdir+logic
logic/fdc_pkg.sv
logic/fdc_regs.sv
logic/fdc_ctrl.sv
logic/fdc_geometry.sv
logic/fdc_timers.sv
logic/fdc_top.sv
tb/fdc_assertions.sv
tb/tb_fdc.sv
